/* common/audio_pkg.sv */
package audio_pkg;

    // Channel counts of the mixer
    localparam int N_MICS      = 4;
    localparam int N_OUTS      = 2;
    localparam int N_COEFS     = N_MICS * N_OUTS;
    localparam int SAMPLE_BITS = 16;

    // ck cycles per sck half period
    localparam int SCK_DIV   = 4;
    localparam int SCK_CNT_W = $clog2(SCK_DIV);
    localparam logic [SCK_CNT_W-1:0] SCK_LAST = SCK_CNT_W'(SCK_DIV - 1);

    // Q1.15 scaling and output limits
    localparam int Q_SHIFT = 15;
    localparam int SAT_MAX = 32767;
    localparam int SAT_MIN = -32768;

    typedef logic signed [SAMPLE_BITS-1:0] sample_t;
    typedef logic signed [15:0]            coef_t;
    typedef logic signed [35:0]            acc_t;
    typedef logic [5:0]                    frame_posn_t;
    typedef logic [2:0]                    coef_idx_t;
    typedef logic [1:0]                    mic_sel_t;

    // Last bit position of the 64-bit frame
    localparam frame_posn_t FRAME_LAST = 6'd63;

    typedef enum logic [1:0] {
        idle,
        mac,
        finish
    } mix_state_t;

    // APB register offsets
    localparam logic [7:0] REG_CTRL      = 8'h00;
    localparam logic [7:0] REG_STATUS    = 8'h04;
    localparam logic [7:0] REG_RESULT    = 8'h08;
    localparam logic [7:0] REG_MIC01     = 8'h0C;
    localparam logic [7:0] REG_MIC23     = 8'h10;
    localparam logic [7:0] REG_COEF_BASE = 8'h40;

endpackage

/* hdl/i2s_clock.sv */
`timescale 1ns/1ps

module i2s_clock (
    input  logic                   ck,
    input  logic                   arst_n,
    output logic                   sck,
    output logic                   ws,
    output audio_pkg::frame_posn_t frame_posn,
    output logic                   tx_en,
    output logic                   rx_en,
    output logic                   frame_start
);

    logic [audio_pkg::SCK_CNT_W-1:0] div_cnt;
    logic                            half_tick;

    assign half_tick = (div_cnt == audio_pkg::SCK_LAST);

    // Strobes mark the ck edge on which sck toggles
    assign rx_en = half_tick && !sck;
    assign tx_en = half_tick && sck;

    // Left half of the frame while ws is low
    assign ws = frame_posn[5];

    always_ff @(posedge ck or negedge arst_n) begin
        if (!arst_n) begin
            div_cnt     <= '0;
            sck         <= 1'b0;
            frame_posn  <= '0;
            frame_start <= 1'b0;
        end else begin
            if (half_tick) begin
                div_cnt <= '0;
                sck     <= !sck;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
            // Position moves on with each falling sck edge
            if (tx_en) begin
                frame_posn <= frame_posn + 1'b1;
            end
            frame_start <= tx_en && (frame_posn == audio_pkg::FRAME_LAST);
        end
    end

    // Frame start pulse lines up with position 0
    assert property (@(posedge ck) disable iff (!arst_n)
        frame_start |-> (frame_posn == '0));

endmodule

/* hdl/i2s_rx.sv */
`timescale 1ns/1ps

module i2s_rx (
    input  logic                   ck,
    input  logic                   arst_n,
    input  logic                   rx_en,
    input  audio_pkg::frame_posn_t frame_posn,
    input  logic                   sd_in0,
    input  logic                   sd_in1,
    output audio_pkg::sample_t     mic0,
    output audio_pkg::sample_t     mic1,
    output audio_pkg::sample_t     mic2,
    output audio_pkg::sample_t     mic3,
    output logic                   frame_valid
);

    logic [4:0]                       slot_posn;
    logic                             in_word;
    logic                             word_end;
    logic [audio_pkg::SAMPLE_BITS-1:0] shift0;
    logic [audio_pkg::SAMPLE_BITS-1:0] shift1;
    logic [audio_pkg::SAMPLE_BITS-1:0] next0;
    logic [audio_pkg::SAMPLE_BITS-1:0] next1;

    // Position within the current half frame
    assign slot_posn = frame_posn[4:0];
    assign in_word   = (slot_posn != 5'd0) && (slot_posn <= 5'(audio_pkg::SAMPLE_BITS));
    assign word_end  = rx_en && (slot_posn == 5'(audio_pkg::SAMPLE_BITS));

    assign next0 = {shift0[audio_pkg::SAMPLE_BITS-2:0], sd_in0};
    assign next1 = {shift1[audio_pkg::SAMPLE_BITS-2:0], sd_in1};

    always_ff @(posedge ck) begin
        if (rx_en && in_word) begin
            shift0 <= next0;
            shift1 <= next1;
        end
    end

    always_ff @(posedge ck or negedge arst_n) begin
        if (!arst_n) begin
            mic0        <= '0;
            mic1        <= '0;
            mic2        <= '0;
            mic3        <= '0;
            frame_valid <= 1'b0;
        end else begin
            // Last data bit is taken straight from the line
            if (word_end && !frame_posn[5]) begin
                mic0 <= next0;
                mic2 <= next1;
            end
            if (word_end && frame_posn[5]) begin
                mic1 <= next0;
                mic3 <= next1;
            end
            frame_valid <= word_end && frame_posn[5];
        end
    end

endmodule

/* hdl/i2s_tx.sv */
`timescale 1ns/1ps

module i2s_tx (
    input  logic                   ck,
    input  logic                   arst_n,
    input  logic                   tx_en,
    input  audio_pkg::frame_posn_t frame_posn,
    input  audio_pkg::sample_t     out_left,
    input  audio_pkg::sample_t     out_right,
    output logic                   sd
);

    logic [2*audio_pkg::SAMPLE_BITS-1:0] shift_reg;
    logic                                load;
    logic                                shift;

    // Load as the frame wraps to position 0
    assign load = tx_en && (frame_posn == audio_pkg::FRAME_LAST);

    // Positions 0-15 and 32-47 lead into a data bit
    assign shift = tx_en && (frame_posn[4:0] < 5'(audio_pkg::SAMPLE_BITS));

    always_ff @(posedge ck or negedge arst_n) begin
        if (!arst_n) begin
            shift_reg <= '0;
        end else if (load) begin
            shift_reg <= {out_left, out_right};
        end else if (shift) begin
            shift_reg <= {shift_reg[2*audio_pkg::SAMPLE_BITS-2:0], 1'b0};
        end
    end

    always_ff @(posedge ck or negedge arst_n) begin
        if (!arst_n) begin
            sd <= 1'b0;
        end else if (tx_en) begin
            // Unused slots carry zeros
            sd <= shift ? shift_reg[2*audio_pkg::SAMPLE_BITS-1] : 1'b0;
        end
    end

endmodule

/* mixer/mix_sequencer.sv */
`timescale 1ns/1ps

module mix_sequencer (
    input  logic                  ck,
    input  logic                  arst_n,
    input  logic                  enable,
    input  logic                  frame_valid,
    input  audio_pkg::sample_t    mic0,
    input  audio_pkg::sample_t    mic1,
    input  audio_pkg::sample_t    mic2,
    input  audio_pkg::sample_t    mic3,
    output audio_pkg::coef_idx_t  coef_idx,
    input  audio_pkg::coef_t      coef_data,
    output audio_pkg::sample_t    out_left,
    output audio_pkg::sample_t    out_right,
    output logic                  mix_done,
    output logic                  sat_flag
);

    audio_pkg::mix_state_t state;
    audio_pkg::acc_t       acc;
    audio_pkg::acc_t       acc_sum;
    audio_pkg::mic_sel_t   mic_sel;
    audio_pkg::sample_t    mic_cur;
    logic signed [31:0]    product;
    logic [16:0]           sat_res;
    logic                  clip_left;
    logic                  last_left;
    logic                  last_right;

    // Returns {clipped, value} of the scaled sum
    function automatic logic [16:0] saturate(input audio_pkg::acc_t sum);
        audio_pkg::acc_t scaled;
        scaled = sum >>> audio_pkg::Q_SHIFT;
        if (scaled > audio_pkg::SAT_MAX) begin
            return {1'b1, 16'h7fff};
        end else if (scaled < audio_pkg::SAT_MIN) begin
            return {1'b1, 16'h8000};
        end
        return {1'b0, scaled[15:0]};
    endfunction

    assign mic_sel = coef_idx[1:0];

    always_comb begin
        case (mic_sel)
            2'd0:    mic_cur = mic0;
            2'd1:    mic_cur = mic1;
            2'd2:    mic_cur = mic2;
            default: mic_cur = mic3;
        endcase
    end

    assign product = coef_data * mic_cur;
    assign acc_sum = acc + product;
    assign sat_res = saturate(acc_sum);

    assign last_left  = (coef_idx == 3'(audio_pkg::N_MICS - 1));
    assign last_right = (coef_idx == 3'(audio_pkg::N_COEFS - 1));

    // Outputs are already updated in the finish cycle
    assign mix_done = (state == audio_pkg::finish);

    always_ff @(posedge ck or negedge arst_n) begin
        if (!arst_n) begin
            state     <= audio_pkg::idle;
            coef_idx  <= '0;
            acc       <= '0;
            out_left  <= '0;
            out_right <= '0;
            sat_flag  <= 1'b0;
            clip_left <= 1'b0;
        end else begin
            case (state)
                audio_pkg::idle: begin
                    if (frame_valid && enable) begin
                        state    <= audio_pkg::mac;
                        coef_idx <= '0;
                        acc      <= '0;
                    end
                end
                audio_pkg::mac: begin
                    if (last_left) begin
                        // Close output 0 and restart for output 1
                        out_left  <= sat_res[15:0];
                        clip_left <= sat_res[16];
                        acc       <= '0;
                    end else begin
                        acc <= acc_sum;
                    end
                    if (last_right) begin
                        out_right <= sat_res[15:0];
                        sat_flag  <= clip_left || sat_res[16];
                        state     <= audio_pkg::finish;
                    end else begin
                        coef_idx <= coef_idx + 1'b1;
                    end
                end
                audio_pkg::finish: begin
                    state    <= audio_pkg::idle;
                    coef_idx <= '0;
                end
                default: begin
                    state <= audio_pkg::idle;
                end
            endcase
        end
    end

    // A new frame never finds the mixer busy
    assert property (@(posedge ck) disable iff (!arst_n)
        frame_valid |-> (state == audio_pkg::idle));

    assert property (@(posedge ck) disable iff (!arst_n) mix_done |=> !mix_done);

endmodule

/* hdl/audio_regs.sv */
`timescale 1ns/1ps

module audio_regs (
    input  logic                 ck,
    input  logic                 arst_n,
    input  logic                 psel,
    input  logic                 penable,
    input  logic                 pwrite,
    input  logic [7:0]           paddr,
    input  logic [31:0]          pwdata,
    output logic [31:0]          prdata,
    output logic                 pslverr,
    input  logic                 frame_start,
    input  logic                 mix_done,
    input  logic                 sat_flag,
    input  audio_pkg::sample_t   out_left,
    input  audio_pkg::sample_t   out_right,
    input  audio_pkg::sample_t   mic0,
    input  audio_pkg::sample_t   mic1,
    input  audio_pkg::sample_t   mic2,
    input  audio_pkg::sample_t   mic3,
    input  audio_pkg::coef_idx_t coef_idx,
    output audio_pkg::coef_t     coef_data,
    output logic                 enable
);

    audio_pkg::coef_t     coef_bank [2][audio_pkg::N_COEFS];
    audio_pkg::coef_idx_t coef_addr;
    logic                 active_bank;
    logic                 swap_pending;
    logic                 sat_sticky;
    logic [15:0]          mix_count;
    logic                 access;
    logic                 wr_en;
    logic                 hit_ctrl;
    logic                 hit_status;
    logic                 hit_result;
    logic                 hit_mic01;
    logic                 hit_mic23;
    logic                 hit_coef;

    // APB access phase
    assign access = psel && penable;
    assign wr_en  = access && pwrite;

    assign hit_ctrl   = (paddr == audio_pkg::REG_CTRL);
    assign hit_status = (paddr == audio_pkg::REG_STATUS);
    assign hit_result = (paddr == audio_pkg::REG_RESULT);
    assign hit_mic01  = (paddr == audio_pkg::REG_MIC01);
    assign hit_mic23  = (paddr == audio_pkg::REG_MIC23);
    assign hit_coef   = (paddr[7:5] == audio_pkg::REG_COEF_BASE[7:5]) && (paddr[1:0] == 2'b00);

    assign coef_addr = paddr[4:2];

    assign pslverr = access &&
        !(hit_ctrl || hit_status || hit_result || hit_mic01 || hit_mic23 || hit_coef);

    // Mixer always reads the active bank
    assign coef_data = coef_bank[active_bank][coef_idx];

    always_comb begin
        prdata = '0;
        if (hit_ctrl) begin
            prdata = {30'd0, swap_pending, enable};
        end else if (hit_status) begin
            prdata = {mix_count, 13'd0, sat_sticky, swap_pending, active_bank};
        end else if (hit_result) begin
            prdata = {out_right, out_left};
        end else if (hit_mic01) begin
            prdata = {mic1, mic0};
        end else if (hit_mic23) begin
            prdata = {mic3, mic2};
        end else if (hit_coef) begin
            // Host sees only the shadow bank
            prdata = {16'd0, coef_bank[!active_bank][coef_addr]};
        end
    end

    always_ff @(posedge ck or negedge arst_n) begin
        if (!arst_n) begin
            enable       <= 1'b0;
            swap_pending <= 1'b0;
            active_bank  <= 1'b0;
            sat_sticky   <= 1'b0;
            mix_count    <= '0;
            for (int b = 0; b < 2; b++) begin
                for (int i = 0; i < audio_pkg::N_COEFS; i++) begin
                    coef_bank[b][i] <= '0;
                end
            end
        end else begin
            // Bank swap only at a frame boundary
            if (frame_start && swap_pending) begin
                active_bank  <= !active_bank;
                swap_pending <= 1'b0;
            end
            if (wr_en && hit_ctrl) begin
                enable <= pwdata[0];
                if (pwdata[1]) begin
                    swap_pending <= 1'b1;
                end
            end
            if (mix_done) begin
                mix_count <= mix_count + 1'b1;
            end
            // A new clip wins over a clear in the same cycle
            if (wr_en && hit_status && pwdata[2]) begin
                sat_sticky <= 1'b0;
            end
            if (mix_done && sat_flag) begin
                sat_sticky <= 1'b1;
            end
            if (wr_en && hit_coef) begin
                coef_bank[!active_bank][coef_addr] <= pwdata[15:0];
            end
        end
    end

    assert property (@(posedge ck) disable iff (!arst_n)
        !frame_start |=> $stable(active_bank));

endmodule

/* hdl/audio_engine.sv */
`timescale 1ns/1ps

module audio_engine (
    input  logic        ck,
    input  logic        arst_n,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [7:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    output logic        sck,
    output logic        ws,
    output logic        sd_out,
    input  logic        sd_in0,
    input  logic        sd_in1
);

    audio_pkg::frame_posn_t frame_posn;
    logic                   tx_en;
    logic                   rx_en;
    logic                   frame_start;
    logic                   frame_valid;
    logic                   enable;
    logic                   mix_done;
    logic                   sat_flag;
    audio_pkg::sample_t     mic0;
    audio_pkg::sample_t     mic1;
    audio_pkg::sample_t     mic2;
    audio_pkg::sample_t     mic3;
    audio_pkg::sample_t     out_left;
    audio_pkg::sample_t     out_right;
    audio_pkg::coef_idx_t   coef_idx;
    audio_pkg::coef_t       coef_data;

    // Registers never insert wait states
    assign pready = 1'b1;

    i2s_clock u_clock (
        .ck          (ck),
        .arst_n      (arst_n),
        .sck         (sck),
        .ws          (ws),
        .frame_posn  (frame_posn),
        .tx_en       (tx_en),
        .rx_en       (rx_en),
        .frame_start (frame_start)
    );

    i2s_rx u_rx (
        .ck          (ck),
        .arst_n      (arst_n),
        .rx_en       (rx_en),
        .frame_posn  (frame_posn),
        .sd_in0      (sd_in0),
        .sd_in1      (sd_in1),
        .mic0        (mic0),
        .mic1        (mic1),
        .mic2        (mic2),
        .mic3        (mic3),
        .frame_valid (frame_valid)
    );

    // Results of frame N go out during frame N+1
    i2s_tx u_tx (
        .ck          (ck),
        .arst_n      (arst_n),
        .tx_en       (tx_en),
        .frame_posn  (frame_posn),
        .out_left    (out_left),
        .out_right   (out_right),
        .sd          (sd_out)
    );

    mix_sequencer u_mixer (
        .ck          (ck),
        .arst_n      (arst_n),
        .enable      (enable),
        .frame_valid (frame_valid),
        .mic0        (mic0),
        .mic1        (mic1),
        .mic2        (mic2),
        .mic3        (mic3),
        .coef_idx    (coef_idx),
        .coef_data   (coef_data),
        .out_left    (out_left),
        .out_right   (out_right),
        .mix_done    (mix_done),
        .sat_flag    (sat_flag)
    );

    audio_regs u_regs (
        .ck          (ck),
        .arst_n      (arst_n),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pslverr     (pslverr),
        .frame_start (frame_start),
        .mix_done    (mix_done),
        .sat_flag    (sat_flag),
        .out_left    (out_left),
        .out_right   (out_right),
        .mic0        (mic0),
        .mic1        (mic1),
        .mic2        (mic2),
        .mic3        (mic3),
        .coef_idx    (coef_idx),
        .coef_data   (coef_data),
        .enable      (enable)
    );

endmodule

/* bench/i2s_codec_model.sv */
`timescale 1ns/1ps

module i2s_codec_model (
    input  logic        sck,
    input  logic        ws,
    input  logic        sd_out,
    input  logic [15:0] mic0,
    input  logic [15:0] mic1,
    input  logic [15:0] mic2,
    input  logic [15:0] mic3,
    output logic        sd_in0,
    output logic        sd_in1,
    output logic [15:0] left_word,
    output logic [15:0] right_word
);

    logic [4:0]  slot;
    logic [4:0]  send_slot;
    logic        last_ws;
    logic        half;
    logic [15:0] line0_l;
    logic [15:0] line0_r;
    logic [15:0] line1_l;
    logic [15:0] line1_r;
    logic [15:0] rx_shift;
    int          bit_idx;

    initial begin
        // Wraps to slot 0 on the first rising sck
        slot       = 5'd31;
        send_slot  = 5'd0;
        last_ws    = 1'b0;
        half       = 1'b0;
        line0_l    = '0;
        line0_r    = '0;
        line1_l    = '0;
        line1_r    = '0;
        rx_shift   = '0;
        bit_idx    = 0;
        sd_in0     = 1'b0;
        sd_in1     = 1'b0;
        left_word  = '0;
        right_word = '0;
    end

    // Slot tracking and sd_out decode on rising sck
    always @(posedge sck) begin
        if (ws != last_ws) begin
            slot = 5'd0;
        end else begin
            slot = slot + 5'd1;
        end
        last_ws = ws;
        half    = ws;
        // New samples are taken only at a frame start
        if ((slot == 5'd0) && !ws) begin
            line0_l = mic0;
            line0_r = mic1;
            line1_l = mic2;
            line1_r = mic3;
        end
        if ((slot >= 5'd1) && (slot <= 5'd16)) begin
            rx_shift = {rx_shift[14:0], sd_out};
        end
        if (slot == 5'd16) begin
            if (ws) begin
                right_word = rx_shift;
            end else begin
                left_word = rx_shift;
            end
        end
    end

    // Next bit goes out just after falling sck, MSB one slot after the ws edge
    always @(negedge sck) begin
        send_slot = slot + 5'd1;
        #1;
        if ((send_slot >= 5'd1) && (send_slot <= 5'd16)) begin
            bit_idx = 16 - int'(send_slot);
            sd_in0  = half ? line0_r[bit_idx] : line0_l[bit_idx];
            sd_in1  = half ? line1_r[bit_idx] : line1_l[bit_idx];
        end else begin
            sd_in0 = 1'b0;
            sd_in1 = 1'b0;
        end
    end

endmodule

/* bench/audio_engine_tb.sv */
`timescale 1ns/1ps

module audio_engine_tb;

    localparam int          N_ROWS     = 9;
    localparam int          WAIT_POLLS = 2000;
    localparam int          HOLD_POLLS = 700;
    localparam logic [31:0] SEED       = 32'h9c1afe14;

    logic             ck;
    logic             arst_n;
    logic             psel;
    logic             penable;
    logic             pwrite;
    logic [7:0]       paddr;
    logic [31:0]      pwdata;
    logic [31:0]      prdata;
    logic             pready;
    logic             pslverr;
    logic             sck;
    logic             ws;
    logic             sd_out;
    logic             sd_in0;
    logic             sd_in1;
    logic [0:3][15:0] drive_mic;
    logic [15:0]      dec_left;
    logic [15:0]      dec_right;

    // Stimulus and expected values, one row per mix setting
    logic [0:3][15:0] tbl_mic   [N_ROWS];
    logic [0:7][15:0] tbl_coef  [N_ROWS];
    logic [15:0]      tbl_left  [N_ROWS];
    logic [15:0]      tbl_right [N_ROWS];
    logic             tbl_clip  [N_ROWS];

    audio_engine UUT (
        .ck      (ck),
        .arst_n  (arst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .sck     (sck),
        .ws      (ws),
        .sd_out  (sd_out),
        .sd_in0  (sd_in0),
        .sd_in1  (sd_in1)
    );

    i2s_codec_model codec (
        .sck        (sck),
        .ws         (ws),
        .sd_out     (sd_out),
        .mic0       (drive_mic[0]),
        .mic1       (drive_mic[1]),
        .mic2       (drive_mic[2]),
        .mic3       (drive_mic[3]),
        .sd_in0     (sd_in0),
        .sd_in1     (sd_in1),
        .left_word  (dec_left),
        .right_word (dec_right)
    );

    always #10 ck = ~ck;

    task automatic stop_run();
        $display("tests failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic timeout_fail(input string what);
        $display("Timeout: %s", what);
        stop_run();
    endtask

    // One output by the Q1.15 rule, clamped to 16 bits
    function automatic void mix_expect(input logic [0:3][15:0] mic,
                                       input logic [0:7][15:0] coef, input int out,
                                       output logic [15:0] value, output logic clip);
        longint sum;
        sum = 0;
        for (int ch = 0; ch < 4; ch++) begin
            sum += longint'($signed(coef[out*4+ch])) * longint'($signed(mic[ch]));
        end
        sum  = sum >>> 15;
        clip = (sum > 32767) || (sum < -32768);
        if (sum > 32767) begin
            value = 16'h7fff;
        end else if (sum < -32768) begin
            value = 16'h8000;
        end else begin
            value = sum[15:0];
        end
    endfunction

    function automatic logic [7:0] coef_addr(input int idx);
        return audio_pkg::REG_COEF_BASE + 8'(4 * idx);
    endfunction

    task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic err);
        @(posedge ck);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge ck);
        #1;
        penable = 1'b1;
        // Mid access cycle, away from the clock edge
        @(negedge ck);
        rdata = prdata;
        err   = pslverr;
        check_value("pready", 32'(pready), 32'd1);
        @(posedge ck);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        logic        err;
        apb_access(1'b1, addr, data, unused, err);
        check_value("pslverr", 32'(err), 32'd0);
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
        logic err;
        apb_access(1'b0, addr, 32'd0, data, err);
        check_value("pslverr", 32'(err), 32'd0);
    endtask

    task automatic wait_ws(input logic level);
        int cycles;
        cycles = 0;
        @(negedge ck);
        while (ws !== level) begin
            assert (cycles < WAIT_POLLS) else timeout_fail("ws never reached the expected level");
            @(negedge ck);
            cycles++;
        end
    endtask

    task automatic wait_swap();
        logic [31:0] d;
        int          polls;
        polls = 0;
        apb_read(audio_pkg::REG_STATUS, d);
        while (d[1]) begin
            assert (polls < WAIT_POLLS) else timeout_fail("bank swap stayed pending");
            apb_read(audio_pkg::REG_STATUS, d);
            polls++;
        end
    endtask

    task automatic wait_count(input logic [15:0] start, input int delta);
        logic [31:0] d;
        logic [15:0] advanced;
        int          polls;
        polls = 0;
        apb_read(audio_pkg::REG_STATUS, d);
        advanced = d[31:16] - start;
        while (int'(advanced) < delta) begin
            assert (polls < WAIT_POLLS) else timeout_fail("mix count did not advance");
            apb_read(audio_pkg::REG_STATUS, d);
            advanced = d[31:16] - start;
            polls++;
        end
    endtask

    task automatic build_table();
        logic [15:0] c;
        logic        clip_l;
        logic        clip_r;
        // Unity gain, left follows mic0 and right follows mic1
        tbl_mic[0]  = {16'h1234, 16'hedcc, 16'h0400, 16'h7000};
        tbl_coef[0] = {16'h7fff, 16'h0000, 16'h0000, 16'h0000,
                       16'h0000, 16'h7fff, 16'h0000, 16'h0000};
        // Negative gains
        tbl_mic[1]  = {16'h2000, 16'h1000, 16'hf000, 16'h0800};
        tbl_coef[1] = {16'h8000, 16'h0000, 16'h0000, 16'h0000,
                       16'h0000, 16'h0000, 16'hc000, 16'h8000};
        // Full scale, clips both ways
        tbl_mic[2]  = {16'h7fff, 16'h7fff, 16'h7fff, 16'h7fff};
        tbl_coef[2] = {16'h7fff, 16'h7fff, 16'h7fff, 16'h7fff,
                       16'h8000, 16'h8000, 16'h8000, 16'h8000};
        // Negative full scale, -1 times -1 just overflows
        tbl_mic[3]  = {16'h8000, 16'h8000, 16'h8000, 16'h8000};
        tbl_coef[3] = {16'h8000, 16'h0000, 16'h0000, 16'h0000,
                       16'h4000, 16'h4000, 16'h0000, 16'h0000};
        tbl_mic[4]  = {16'h1000, 16'h2000, 16'he000, 16'h0100};
        tbl_coef[4] = {8{16'h2000}};
        for (int r = 5; r < N_ROWS; r++) begin
            for (int ch = 0; ch < 4; ch++) begin
                tbl_mic[r][ch] = 16'($urandom());
            end
            // Last rows use quarter range gains
            for (int k = 0; k < 8; k++) begin
                c = 16'($urandom());
                tbl_coef[r][k] = (r >= 7) ? {{2{c[15]}}, c[15:2]} : c;
            end
        end
        for (int r = 0; r < N_ROWS; r++) begin
            mix_expect(tbl_mic[r], tbl_coef[r], 0, tbl_left[r], clip_l);
            mix_expect(tbl_mic[r], tbl_coef[r], 1, tbl_right[r], clip_r);
            tbl_clip[r] = clip_l || clip_r;
        end
    endtask

    task automatic check_reset();
        logic [31:0] d;
        logic        err;
        apb_read(audio_pkg::REG_CTRL, d);
        check_value("CTRL", d, 32'd0);
        apb_read(audio_pkg::REG_STATUS, d);
        check_value("STATUS", d, 32'd0);
        apb_read(audio_pkg::REG_RESULT, d);
        check_value("RESULT", d, 32'd0);
        // A gap, past the coefficients, and a misaligned offset
        apb_access(1'b0, 8'h20, 32'd0, d, err);
        check_value("pslverr", 32'(err), 32'd1);
        apb_access(1'b1, 8'h60, 32'hffff_ffff, d, err);
        check_value("pslverr", 32'(err), 32'd1);
        apb_access(1'b0, 8'h42, 32'd0, d, err);
        check_value("pslverr", 32'(err), 32'd1);
        // Watch one whole frame from its start
        wait_ws(1'b1);
        wait_ws(1'b0);
        for (int i = 0; i < 512; i++) begin
            @(negedge ck);
            check_value("sd_out", 32'(sd_out), 32'd0);
        end
    endtask

    task automatic check_bank_swap();
        logic [31:0] d;
        for (int i = 0; i < 8; i++) begin
            apb_write(coef_addr(i), 32'hbeef_0000 | (32'h1111 * (i + 1)));
        end
        for (int i = 0; i < 8; i++) begin
            apb_read(coef_addr(i), d);
            check_value("COEF", d, 32'h1111 * (i + 1));
        end
        // Request mid frame, well away from frame_start
        wait_ws(1'b0);
        wait_ws(1'b1);
        apb_write(audio_pkg::REG_CTRL, 32'h2);
        apb_read(audio_pkg::REG_STATUS, d);
        check_value("STATUS", d, 32'h2);
        wait_swap();
        apb_read(audio_pkg::REG_STATUS, d);
        check_value("STATUS", d, 32'h1);
        // Shadow is now bank 0, still at its reset value
        for (int i = 0; i < 8; i++) begin
            apb_read(coef_addr(i), d);
            check_value("COEF", d, 32'd0);
        end
    endtask

    task automatic run_row(input int r);
        logic [31:0] d;
        logic [15:0] start;
        for (int k = 0; k < 8; k++) begin
            apb_write(coef_addr(k), {16'd0, tbl_coef[r][k]});
        end
        apb_write(audio_pkg::REG_CTRL, 32'h3);
        wait_swap();
        drive_mic = tbl_mic[r];
        apb_read(audio_pkg::REG_STATUS, d);
        start = d[31:16];
        // Two mixes later one full frame has used the new samples
        wait_count(start, 2);
        apb_read(audio_pkg::REG_MIC01, d);
        check_value("MIC01", d, {tbl_mic[r][1], tbl_mic[r][0]});
        apb_read(audio_pkg::REG_MIC23, d);
        check_value("MIC23", d, {tbl_mic[r][3], tbl_mic[r][2]});
        apb_read(audio_pkg::REG_RESULT, d);
        check_value("RESULT", d, {tbl_right[r], tbl_left[r]});
        apb_write(audio_pkg::REG_STATUS, 32'h4);
        apb_read(audio_pkg::REG_STATUS, d);
        check_value("STATUS.sat", 32'(d[2]), 32'd0);
        wait_count(start, 3);
        apb_read(audio_pkg::REG_STATUS, d);
        check_value("STATUS.sat", 32'(d[2]), 32'(tbl_clip[r]));
        // Codec has decoded the previous frame's mix by now
        check_value("sd_out left", 32'(dec_left), 32'(tbl_left[r]));
        check_value("sd_out right", 32'(dec_right), 32'(tbl_right[r]));
    endtask

    task automatic check_hold();
        logic [31:0] d;
        logic [15:0] count;
        apb_write(audio_pkg::REG_CTRL, 32'h0);
        apb_read(audio_pkg::REG_CTRL, d);
        check_value("CTRL", d, 32'd0);
        apb_read(audio_pkg::REG_STATUS, d);
        count = d[31:16];
        // New input, so a stray mix would show in RESULT
        for (int ch = 0; ch < 4; ch++) begin
            drive_mic[ch] = 16'($urandom());
        end
        for (int i = 0; i < HOLD_POLLS; i++) begin
            apb_read(audio_pkg::REG_STATUS, d);
            check_value("STATUS.count", 32'(d[31:16]), 32'(count));
        end
        apb_read(audio_pkg::REG_RESULT, d);
        check_value("RESULT", d, {tbl_right[N_ROWS-1], tbl_left[N_ROWS-1]});
    endtask

    initial begin
        ck        = 1'b0;
        arst_n    = 1'b0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        drive_mic = '0;
        void'($urandom(SEED));
        build_table();
        repeat (5) @(posedge ck);
        #1;
        // Outputs sit at their reset levels
        check_value("sck", 32'(sck), 32'd0);
        check_value("ws", 32'(ws), 32'd0);
        check_value("sd_out", 32'(sd_out), 32'd0);
        check_value("pslverr", 32'(pslverr), 32'd0);
        arst_n = 1'b1;
        check_reset();
        check_bank_swap();
        for (int r = 0; r < N_ROWS; r++) begin
            run_row(r);
        end
        check_hold();
        $display("all tests passed");
        $finish;
    end

endmodule

/* audio_engine.f */
common/audio_pkg.sv
hdl/i2s_clock.sv
hdl/i2s_rx.sv
hdl/i2s_tx.sv
mixer/mix_sequencer.sv
hdl/audio_regs.sv
hdl/audio_engine.sv
bench/i2s_codec_model.sv
bench/audio_engine_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= audio_engine_tb
RTL_TOP   ?= audio_engine
FILELIST  ?= audio_engine.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only -Wall --timing
PASS_TEXT ?= all tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
